// ==== build.f ====
mem_pkg.sv
bus_pkg.sv
burst_if.sv
line_burst_master.sv
bus_arbiter.sv
burst_memory.sv
line_system.sv
line_system_sva.sv
tb_line_system.sv

// ==== burst_if.sv ====
`timescale 1ns/1ps

interface burst_if
  import mem_pkg::*;
();

  // command channel
  logic  cmd_valid;
  logic  cmd_write;                                   // 1 write, 0 read
  addr_t cmd_addr;                                    // line aligned byte address
  logic  cmd_ready;

  // write beats are never stalled
  word_t wdata;
  logic  wvalid;
  logic  wlast;

  // read beats are never stalled
  word_t rdata;
  logic  rvalid;
  logic  rlast;

  logic  bdone;                                       // one cycle after wlast

  modport master (
    output cmd_valid, cmd_write, cmd_addr,
    input  cmd_ready,
    output wdata, wvalid, wlast,
    input  rdata, rvalid, rlast,
    input  bdone
  );

  modport slave (
    input  cmd_valid, cmd_write, cmd_addr,
    output cmd_ready,
    input  wdata, wvalid, wlast,
    output rdata, rvalid, rlast,
    output bdone
  );

endinterface

// ==== burst_memory.sv ====
`timescale 1ns/1ps

module burst_memory
  import mem_pkg::*;
#(
  parameter addr_t MEM_BASE       = '0,
  parameter int    READ_DELAY     = 1,
  parameter int    MEM_WORDS_LOG2 = 10
)
(
  input  logic   clk,
  input  logic   reset,
  burst_if.slave bus
);

  localparam int DEPTH = 2 ** MEM_WORDS_LOG2;
  localparam int DLY_W = $clog2(READ_DELAY + 1);

  typedef logic [MEM_WORDS_LOG2-1:0] idx_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_DELAY,
    ST_READ,
    ST_WRITE,
    ST_BDONE
  } state_t;

  word_t            mem [DEPTH];
  state_t           state;
  idx_t             base_idx;                         // first word of the line
  idx_t             idx;
  beat_cnt_t        beat;
  logic [DLY_W-1:0] dly_cnt;
  addr_t            offset;
  logic             last_beat;

  assign offset    = bus.cmd_addr - MEM_BASE;         // window relative address
  assign idx       = base_idx + idx_t'(beat);         // wraps inside the array
  assign last_beat = (beat == beat_cnt_t'(BLOCK_SIZE - 1));

  ////////////////////////////////////////
  // bus side
  ////////////////////////////////////////

  assign bus.cmd_ready = (state == ST_IDLE);
  assign bus.rvalid    = (state == ST_READ);
  assign bus.rlast     = bus.rvalid && last_beat;
  assign bus.rdata     = mem[idx];
  assign bus.bdone     = (state == ST_BDONE);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state   <= ST_IDLE;
      beat    <= '0;
      dly_cnt <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (bus.cmd_valid)
          begin
            beat    <= '0;
            dly_cnt <= DLY_W'(READ_DELAY - 1);
            if (bus.cmd_write)
              state <= ST_WRITE;
            else if (READ_DELAY > 1)
              state <= ST_DELAY;
            else
              state <= ST_READ;
          end
        end
        ST_DELAY:
        begin
          dly_cnt <= dly_cnt - 1'b1;
          if (dly_cnt == DLY_W'(1))                   // next cycle is READ_DELAY after command
            state <= ST_READ;
        end
        ST_READ:
        begin
          beat <= beat + 1'b1;
          if (last_beat)
            state <= ST_IDLE;
        end
        ST_WRITE:
        begin
          if (bus.wvalid)
          begin
            beat <= beat + 1'b1;
            if (bus.wlast)
              state <= ST_BDONE;
          end
        end
        ST_BDONE: state <= ST_IDLE;
        default:  state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && bus.cmd_valid)
      base_idx <= offset[MEM_WORDS_LOG2+1:2];         // word index without the byte bits
  end

  always_ff @(posedge clk)
  begin
    if (state == ST_WRITE && bus.wvalid)
      mem[idx] <= bus.wdata;
  end

endmodule

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter
  import bus_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  burst_if.slave  m0,
  burst_if.slave  m1,
  burst_if.master mem
);

  master_sel_t owner;                                 // holder of the current burst
  master_sel_t last_served;                           // loses the next tie
  master_sel_t pick;
  master_sel_t cur;
  logic        held;
  logic        cmd_fire;
  logic        burst_end;

  ////////////////////////////////////////
  // grant selection
  ////////////////////////////////////////

  always_comb
  begin
    if (m0.cmd_valid && m1.cmd_valid)
      pick = (last_served == SEL_M0) ? SEL_M1 : SEL_M0;
    else if (m1.cmd_valid)
      pick = SEL_M1;
    else
      pick = SEL_M0;
  end

  assign cur       = held ? owner : pick;             // free bus follows the request at once
  assign cmd_fire  = !held && mem.cmd_valid && mem.cmd_ready;
  assign burst_end = mem.bdone || (mem.rvalid && mem.rlast);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      held        <= 1'b0;
      owner       <= SEL_M0;
      last_served <= SEL_M1;                          // m0 wins the first tie
    end
    else if (cmd_fire)
    begin
      held  <= 1'b1;
      owner <= pick;
    end
    else if (held && burst_end)
    begin
      held        <= 1'b0;
      last_served <= owner;
    end
  end

  ////////////////////////////////////////
  // steering
  ////////////////////////////////////////

  always_comb
  begin
    if (cur == SEL_M1)
    begin
      mem.cmd_valid = m1.cmd_valid;
      mem.cmd_write = m1.cmd_write;
      mem.cmd_addr  = m1.cmd_addr;
      mem.wdata     = m1.wdata;
      mem.wvalid    = m1.wvalid;
      mem.wlast     = m1.wlast;
    end
    else
    begin
      mem.cmd_valid = m0.cmd_valid;
      mem.cmd_write = m0.cmd_write;
      mem.cmd_addr  = m0.cmd_addr;
      mem.wdata     = m0.wdata;
      mem.wvalid    = m0.wvalid;
      mem.wlast     = m0.wlast;
    end
  end

  // only the owner sees ready, beats and bdone
  assign m0.cmd_ready = mem.cmd_ready && (cur == SEL_M0);
  assign m0.rdata     = mem.rdata;
  assign m0.rvalid    = mem.rvalid && (cur == SEL_M0);
  assign m0.rlast     = mem.rlast && (cur == SEL_M0);
  assign m0.bdone     = mem.bdone && (cur == SEL_M0);

  assign m1.cmd_ready = mem.cmd_ready && (cur == SEL_M1);
  assign m1.rdata     = mem.rdata;
  assign m1.rvalid    = mem.rvalid && (cur == SEL_M1);
  assign m1.rlast     = mem.rlast && (cur == SEL_M1);
  assign m1.bdone     = mem.bdone && (cur == SEL_M1);

endmodule

// ==== bus_pkg.sv ====
package bus_pkg;

  ////////////////////////////////////////
  // burst bus defaults
  ////////////////////////////////////////

  // the memory answers from this base upward
  localparam logic [31:0] DEFAULT_MEM_BASE = 32'h3000_0000;

  localparam int DEFAULT_READ_DELAY = 10;             // read command to first beat

  ////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////

  typedef enum logic {
    SEL_M0 = 1'b0,                                    // master 0 owns the bus
    SEL_M1 = 1'b1                                     // master 1 owns the bus
  } master_sel_t;

endpackage

// ==== line_burst_master.sv ====
`timescale 1ns/1ps

module line_burst_master
  import mem_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    req,
  input  logic    write,
  input  addr_t   addr,
  input  line_t   wline,
  output logic    busy,
  output logic    done,
  output line_t   rline,
  burst_if.master bus
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CMD,
    ST_BEATS,
    ST_WAIT
  } state_t;

  state_t    state;
  beat_cnt_t beat;
  logic      write_q;
  addr_t     addr_q;
  line_t     wline_q;
  logic      cmd_fire;

  assign cmd_fire = bus.cmd_valid && bus.cmd_ready;

  ////////////////////////////////////////
  // request capture
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (req && state == ST_IDLE)
    begin
      write_q <= write;
      addr_q  <= {addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};  // drop byte offset
      wline_q <= wline;
    end
  end

  ////////////////////////////////////////
  // transfer FSM
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= ST_IDLE;
      beat  <= '0;
      done  <= 1'b0;
    end
    else
    begin
      done <= 1'b0;                                   // single cycle pulse
      case (state)
        ST_IDLE:
        begin
          if (req)
            state <= ST_CMD;
        end
        ST_CMD:
        begin
          beat <= '0;
          if (cmd_fire)
            state <= ST_BEATS;
        end
        ST_BEATS:
        begin
          if (write_q)
          begin
            beat <= beat + 1'b1;                      // one word per cycle
            if (bus.wlast)
              state <= ST_WAIT;
          end
          else if (bus.rvalid)
          begin
            beat <= beat + 1'b1;
            if (bus.rlast)
            begin
              state <= ST_IDLE;
              done  <= 1'b1;
            end
          end
        end
        ST_WAIT:
        begin
          if (bus.bdone)                              // memory has taken the line
          begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // read words land in their slot of the line
  always_ff @(posedge clk)
  begin
    if (state == ST_BEATS && !write_q && bus.rvalid)
      rline[beat*DATA_WIDTH +: DATA_WIDTH] <= bus.rdata;
  end

  assign busy          = (state != ST_IDLE);
  assign bus.cmd_valid = (state == ST_CMD);
  assign bus.cmd_write = write_q;
  assign bus.cmd_addr  = addr_q;
  assign bus.wvalid    = (state == ST_BEATS) && write_q;
  assign bus.wlast     = bus.wvalid && (beat == beat_cnt_t'(BLOCK_SIZE - 1));
  assign bus.wdata     = wline_q[beat*DATA_WIDTH +: DATA_WIDTH];  // word 0 first

endmodule

// ==== line_system.sv ====
`timescale 1ns/1ps

module line_system
  import mem_pkg::*, bus_pkg::*;
#(
  parameter addr_t MEM_BASE       = DEFAULT_MEM_BASE,
  parameter int    READ_DELAY     = DEFAULT_READ_DELAY,
  parameter int    MEM_WORDS_LOG2 = 10
)
(
  input  logic  clk,
  input  logic  reset,

  // master 0
  input  logic  m0_req,
  input  logic  m0_write,
  input  addr_t m0_addr,
  input  line_t m0_wline,
  output logic  m0_busy,
  output logic  m0_done,
  output line_t m0_rline,

  // master 1
  input  logic  m1_req,
  input  logic  m1_write,
  input  addr_t m1_addr,
  input  line_t m1_wline,
  output logic  m1_busy,
  output logic  m1_done,
  output line_t m1_rline
);

  burst_if bus_m0 ();
  burst_if bus_m1 ();
  burst_if bus_mem ();                                // arbiter to memory

  ////////////////////////////////////////
  // line masters
  ////////////////////////////////////////

  line_burst_master u_master0 (
    .clk   (clk),
    .reset (reset),
    .req   (m0_req),
    .write (m0_write),
    .addr  (m0_addr),
    .wline (m0_wline),
    .busy  (m0_busy),
    .done  (m0_done),
    .rline (m0_rline),
    .bus   (bus_m0.master)
  );

  line_burst_master u_master1 (
    .clk   (clk),
    .reset (reset),
    .req   (m1_req),
    .write (m1_write),
    .addr  (m1_addr),
    .wline (m1_wline),
    .busy  (m1_busy),
    .done  (m1_done),
    .rline (m1_rline),
    .bus   (bus_m1.master)
  );

  ////////////////////////////////////////
  // shared memory path
  ////////////////////////////////////////

  bus_arbiter u_arbiter (
    .clk   (clk),
    .reset (reset),
    .m0    (bus_m0.slave),
    .m1    (bus_m1.slave),
    .mem   (bus_mem.master)
  );

  burst_memory #(
    .MEM_BASE       (MEM_BASE),
    .READ_DELAY     (READ_DELAY),
    .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
  ) u_memory (
    .clk   (clk),
    .reset (reset),
    .bus   (bus_mem.slave)
  );

endmodule

// ==== line_system_sva.sv ====
`timescale 1ns/1ps

module line_system_sva
  import mem_pkg::*;
#(
  parameter bit GRANT_CHECK = 1'b0
)
(
  input logic  clk,
  input logic  reset,
  input logic  cmd_valid,
  input logic  cmd_write,
  input addr_t cmd_addr,
  input logic  cmd_ready,
  input logic  wvalid,
  input logic  wlast,
  input logic  rvalid,
  input logic  rlast,
  input logic  bdone,
  input logic  grant
);

  int fails = 0;                                      // failed assertion count

  generate
    if (GRANT_CHECK)
    begin : g_grant
      // the steered master stays put while the memory is busy
      a_grant_stable: assert property (@(posedge clk) disable iff (reset)
        !cmd_ready |-> $stable(grant))
        else
        begin
          $error("bus owner changed inside a burst");
          fails++;
        end
    end
    else
    begin : g_bus
      a_cmd_hold: assert property (@(posedge clk) disable iff (reset)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_addr) && $stable(cmd_write))
        else
        begin
          $error("command dropped or changed before handshake");
          fails++;
        end

      // eight beats with rlast only on the eighth
      a_read_len: assert property (@(posedge clk) disable iff (reset)
        $rose(rvalid) |-> (rvalid && !rlast) [*7] ##1 (rvalid && rlast))
        else
        begin
          $error("read burst is not eight beats ending in rlast");
          fails++;
        end

      a_read_end: assert property (@(posedge clk) disable iff (reset)
        rlast |=> !rvalid)
        else
        begin
          $error("rvalid continues after rlast");
          fails++;
        end

      a_bdone_after: assert property (@(posedge clk) disable iff (reset)
        wvalid && wlast |=> bdone)
        else
        begin
          $error("bdone missing one cycle after wlast");
          fails++;
        end

      a_bdone_src: assert property (@(posedge clk) disable iff (reset)
        bdone |-> $past(wlast))
        else
        begin
          $error("bdone without a preceding wlast");
          fails++;
        end
    end
  endgenerate

endmodule

////////////////////////////////////////
// attachment points
////////////////////////////////////////

bind burst_memory line_system_sva #(.GRANT_CHECK(1'b0)) u_sva (
  .clk       (clk),
  .reset     (reset),
  .cmd_valid (bus.cmd_valid),
  .cmd_write (bus.cmd_write),
  .cmd_addr  (bus.cmd_addr),
  .cmd_ready (bus.cmd_ready),
  .wvalid    (bus.wvalid),
  .wlast     (bus.wlast),
  .rvalid    (bus.rvalid),
  .rlast     (bus.rlast),
  .bdone     (bus.bdone),
  .grant     (1'b0)
);

// each master bus, where a command can wait for the grant
bind line_burst_master line_system_sva #(.GRANT_CHECK(1'b0)) u_sva (
  .clk       (clk),
  .reset     (reset),
  .cmd_valid (bus.cmd_valid),
  .cmd_write (bus.cmd_write),
  .cmd_addr  (bus.cmd_addr),
  .cmd_ready (bus.cmd_ready),
  .wvalid    (bus.wvalid),
  .wlast     (bus.wlast),
  .rvalid    (bus.rvalid),
  .rlast     (bus.rlast),
  .bdone     (bus.bdone),
  .grant     (1'b0)
);

bind bus_arbiter line_system_sva #(.GRANT_CHECK(1'b1)) u_sva (
  .clk       (clk),
  .reset     (reset),
  .cmd_valid (mem.cmd_valid),
  .cmd_write (mem.cmd_write),
  .cmd_addr  (mem.cmd_addr),
  .cmd_ready (mem.cmd_ready),
  .wvalid    (mem.wvalid),
  .wlast     (mem.wlast),
  .rvalid    (mem.rvalid),
  .rlast     (mem.rlast),
  .bdone     (mem.bdone),
  .grant     (cur)
);

// ==== mem_pkg.sv ====
package mem_pkg;

  ////////////////////////////////////////
  // word and address geometry
  ////////////////////////////////////////

  localparam int DATA_WIDTH = 32;                     // bits per word
  localparam int ADDR_WIDTH = 32;                     // byte address

  ////////////////////////////////////////
  // line geometry
  ////////////////////////////////////////

  localparam int BLOCK_SIZE   = 8;                    // words per line
  localparam int OFFSET_WIDTH = $clog2(DATA_WIDTH * BLOCK_SIZE / 8);  // byte offset in a line

  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // word 0 sits in the lowest bits of the line
  typedef logic [BLOCK_SIZE*DATA_WIDTH-1:0] line_t;

  typedef logic [$clog2(BLOCK_SIZE)-1:0] beat_cnt_t;  // one count per beat of a burst

endpackage

// ==== tb_line_system.sv ====
`timescale 1ns/1ps

module tb_line_system
  import mem_pkg::*, bus_pkg::*;
();

  localparam int    WORDS_LOG2 = 10;
  localparam int    DEPTH      = 2 ** WORDS_LOG2;
  localparam int    LINES      = DEPTH / BLOCK_SIZE;
  localparam int    TIMEOUT    = 200;                 // cycles per wait
  localparam int    SKEW       = 5;                   // drive delay after the edge
  localparam addr_t MEM_BASE   = DEFAULT_MEM_BASE;

  logic  clk;
  logic  reset;
  logic  m0_req, m0_write, m0_busy, m0_done;
  addr_t m0_addr;
  line_t m0_wline, m0_rline;
  logic  m1_req, m1_write, m1_busy, m1_done;
  addr_t m1_addr;
  line_t m1_wline, m1_rline;

  word_t       ref_mem [DEPTH];                       // mirror of the memory contents
  bit          line_written [LINES];
  line_t       exp_line [2];
  string       op_name [2];
  bit          read_pending [2];
  bit          done_seen [2];
  logic [31:0] rng;
  int          mismatches;
  int          timeouts;
  int          sva_fails;

  line_system #(
    .MEM_BASE       (MEM_BASE),
    .READ_DELAY     (DEFAULT_READ_DELAY),
    .MEM_WORDS_LOG2 (WORDS_LOG2)
  ) UUT (
    .clk      (clk),
    .reset    (reset),
    .m0_req   (m0_req),
    .m0_write (m0_write),
    .m0_addr  (m0_addr),
    .m0_wline (m0_wline),
    .m0_busy  (m0_busy),
    .m0_done  (m0_done),
    .m0_rline (m0_rline),
    .m1_req   (m1_req),
    .m1_write (m1_write),
    .m1_addr  (m1_addr),
    .m1_wline (m1_wline),
    .m1_busy  (m1_busy),
    .m1_done  (m1_done),
    .m1_rline (m1_rline)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // offset bits ignored, base removed, index wraps at the memory depth
  function automatic int word_index(input addr_t a, input int beat);
    addr_t off;
    off = {a[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}} - MEM_BASE;
    return (int'(off[ADDR_WIDTH-1:2]) + beat) % DEPTH;
  endfunction

  function automatic line_t expected_line(input addr_t a);
    line_t l;
    int    i;
    for (i = 0; i < BLOCK_SIZE; i++)
      l[i*DATA_WIDTH +: DATA_WIDTH] = ref_mem[word_index(a, i)];
    return l;
  endfunction

  task automatic mirror_write(input addr_t a, input line_t d);
    int i;
    for (i = 0; i < BLOCK_SIZE; i++)
      ref_mem[word_index(a, i)] = d[i*DATA_WIDTH +: DATA_WIDTH];
    line_written[word_index(a, 0) / BLOCK_SIZE] = 1'b1;
  endtask

  task automatic next_rand(output word_t w);
    rng = lcg(rng);
    w   = rng;
  endtask

  task automatic rand_line(output line_t l);
    word_t w;
    int    i;
    for (i = 0; i < BLOCK_SIZE; i++)
    begin
      next_rand(w);
      l[i*DATA_WIDTH +: DATA_WIDTH] = w;
    end
  endtask

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic compare_line(input string name, input line_t exp, input line_t act);
    if (act !== exp)
    begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      mismatches++;
    end
  endtask

  task automatic verify_level(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      mismatches++;
    end
  endtask

  // read lines are checked on the done pulse
  task automatic note_done(input int m, input logic done, input logic busy, input line_t rline);
    if (done)
    begin
      done_seen[m] = 1'b1;
      verify_level({op_name[m], " busy at done"}, 1'b0, busy);
      if (read_pending[m])
      begin
        compare_line(op_name[m], exp_line[m], rline);
        read_pending[m] = 1'b0;
      end
    end
  endtask

  always @(negedge clk)
  begin
    if (!reset)
    begin
      note_done(0, m0_done, m0_busy, m0_rline);
      note_done(1, m1_done, m1_busy, m1_rline);
    end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  task automatic post_request(input int m, input logic wr, input addr_t a, input line_t d,
                              input string name);
    done_seen[m] = 1'b0;
    op_name[m]   = name;
    read_pending[m] = !wr;
    if (wr)
      mirror_write(a, d);
    else
      exp_line[m] = expected_line(a);                 // snapshot before the transfer
    if (m == 0)
    begin
      m0_req   = 1'b1;
      m0_write = wr;
      m0_addr  = a;
      m0_wline = d;
    end
    else
    begin
      m1_req   = 1'b1;
      m1_write = wr;
      m1_addr  = a;
      m1_wline = d;
    end
  endtask

  task automatic drop_request(input bit go0, input bit go1);
    @(posedge clk);
    #SKEW;
    m0_req = 1'b0;
    m1_req = 1'b0;
    if (go0)
      verify_level({op_name[0], " busy after request"}, 1'b1, m0_busy);
    if (go1)
      verify_level({op_name[1], " busy after request"}, 1'b1, m1_busy);
  endtask

  task automatic await_done(input bit go0, input bit go1);
    int cycles;
    cycles = 0;
    while (((go0 && !done_seen[0]) || (go1 && !done_seen[1])) && cycles < TIMEOUT)
    begin
      @(posedge clk);
      cycles++;
    end
    if ((go0 && !done_seen[0]) || (go1 && !done_seen[1]))
    begin
      $display("timeout: a master did not signal done within %0d cycles", TIMEOUT);
      timeouts++;
    end
    #SKEW;
  endtask

  task automatic run_op(input int m, input logic wr, input addr_t a, input line_t d,
                        input string name);
    post_request(m, wr, a, d, name);
    drop_request(m == 0, m == 1);
    await_done(m == 0, m == 1);
  endtask

  task automatic random_request(input int m, input int line, input int iter);
    word_t r;
    line_t d;
    addr_t a;
    logic  wr;
    next_rand(r);
    wr = r[16] || !line_written[line];                // reads only from written lines
    a  = MEM_BASE + addr_t'(line * BLOCK_SIZE * 4) + addr_t'(r[24:20]);
    if (r[27])
      a = a + addr_t'(4 * DEPTH);                     // alias above the window
    rand_line(d);
    post_request(m, wr, a, d, $sformatf("random %0d m%0d %s", iter, m, wr ? "write" : "read"));
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial
  begin
    line_t d0;
    line_t d1;
    word_t r;
    int    line0;
    int    line1;
    int    iter;
    rng        = 32'hec88;
    mismatches = 0;
    timeouts   = 0;
    done_seen  = '{default: 1'b0};
    read_pending = '{default: 1'b0};
    op_name    = '{default: "idle"};
    m0_req   = 1'b0;
    m0_write = 1'b0;
    m0_addr  = '0;
    m0_wline = '0;
    m1_req   = 1'b0;
    m1_write = 1'b0;
    m1_addr  = '0;
    m1_wline = '0;
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #SKEW;
    reset = 1'b0;

    verify_level("reset m0_busy", 1'b0, m0_busy);
    verify_level("reset m1_busy", 1'b0, m1_busy);
    verify_level("reset m0_done", 1'b0, m0_done);
    verify_level("reset m1_done", 1'b0, m1_done);

    rand_line(d0);
    run_op(0, 1'b1, MEM_BASE + 32'h40, d0, "round trip write");
    run_op(0, 1'b0, MEM_BASE + 32'h40, '0, "round trip read");

    rand_line(d1);
    run_op(1, 1'b1, MEM_BASE + 32'h100, d1, "shared write m1");
    run_op(0, 1'b0, MEM_BASE + 32'h100, '0, "shared read m0");

    // both masters request in the same cycle
    rand_line(d0);
    rand_line(d1);
    post_request(0, 1'b1, MEM_BASE + 32'h200, d0, "contention write m0");
    post_request(1, 1'b1, MEM_BASE + 32'h260, d1, "contention write m1");
    drop_request(1'b1, 1'b1);
    await_done(1'b1, 1'b1);
    post_request(0, 1'b0, MEM_BASE + 32'h260, '0, "contention read m0");
    post_request(1, 1'b0, MEM_BASE + 32'h200, '0, "contention read m1");
    drop_request(1'b1, 1'b1);
    await_done(1'b1, 1'b1);

    rand_line(d0);
    run_op(0, 1'b1, MEM_BASE + addr_t'(4 * DEPTH), d0, "window wrap write");
    run_op(1, 1'b0, MEM_BASE, '0, "window wrap read");

    for (iter = 0; iter < 20; iter++)
    begin
      next_rand(r);
      line0 = (r >> 16) % LINES;
      next_rand(r);
      line1 = (line0 + 1 + (r >> 16) % (LINES - 1)) % LINES;  // never the same line
      random_request(0, line0, iter);
      random_request(1, line1, iter);
      drop_request(1'b1, 1'b1);
      await_done(1'b1, 1'b1);
    end

    repeat (2) @(posedge clk);
    sva_fails = UUT.u_memory.u_sva.fails + UUT.u_arbiter.u_sva.fails
              + UUT.u_master0.u_sva.fails + UUT.u_master1.u_sva.fails;
    $display("mismatches: %0d  timeouts: %0d  assertion failures: %0d",
             mismatches, timeouts, sva_fails);
    if (mismatches == 0 && timeouts == 0 && sva_fails == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule
